// ==== src/switch_defs.svh ====
`ifndef SWITCH_DEFS_SVH
`define SWITCH_DEFS_SVH

// Switch dimensions.
`define SW_PORTS       4
`define SW_DATA_W      16

// Entries in each source queue of an output buffer.
`define SW_QUEUE_DEPTH 8

`endif

// ==== src/switch_pkg.sv ====
`include "switch_defs.svh"

package switch_pkg;

    // Index of an input or output port.
    typedef logic [$clog2(`SW_PORTS)-1:0] port_t;

    // Payload word of one cell.
    typedef logic [`SW_DATA_W-1:0] data_t;

    // One captured cell.
    // src is the input port it entered on.
    typedef struct packed {
        port_t src;
        port_t dest;
        data_t data;
    } cell_t;

endpackage

// ==== src/cell_lane_if.sv ====
`timescale 1ns/1ps

interface cell_lane_if;
    import switch_pkg::*;

    // A cell sits on the lane for the current slot while valid is high.
    logic  valid;
    port_t src;
    port_t dest;
    data_t data;

    modport sender (
        output valid,
        output src,
        output dest,
        output data
    );

    modport receiver (
        input valid,
        input src,
        input dest,
        input data
    );

endinterface

// ==== src/frame_rotator.sv ====
`timescale 1ns/1ps
`include "switch_defs.svh"

module frame_rotator (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [`SW_PORTS-1:0]                            vld_in,
    input  logic [`SW_PORTS*$bits(switch_pkg::port_t)-1:0]  dest_in,
    input  logic [`SW_PORTS*`SW_DATA_W-1:0]                 data_in,
    input  logic [`SW_PORTS-1:0]                            alm_full_in,
    output logic                                            ready,
    cell_lane_if.sender                                     lanes [`SW_PORTS]
);
    import switch_pkg::*;

    localparam int    PW        = $bits(port_t);
    localparam port_t LAST_SLOT = port_t'(`SW_PORTS - 1);

    port_t                slot;
    logic [`SW_PORTS-1:0] frame_vld;
    cell_t                frame_cell [`SW_PORTS];
    cell_t                cell_in [`SW_PORTS];

    // ******************************************************************
    // Slot counter and frame acceptance.
    // ******************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // Frames are taken only at the boundary, and never while a queue is close to full.
    assign ready = (slot == LAST_SLOT) && !(|alm_full_in);

    for (genvar i = 0; i < `SW_PORTS; i++) begin : g_cell_in
        assign cell_in[i] = {port_t'(i), dest_in[i*PW +: PW], data_in[i*`SW_DATA_W +: `SW_DATA_W]};
    end

    // A refused frame becomes an empty one.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_vld <= '0;
        end else if (slot == LAST_SLOT) begin
            frame_vld <= ready ? vld_in : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (slot == LAST_SLOT && ready) begin
            frame_cell <= cell_in;
        end
    end

    // ******************************************************************
    // Rotation onto the output lanes.
    // ******************************************************************

    // Lane o shows input (o - slot) mod N, so each input meets every lane once.
    for (genvar o = 0; o < `SW_PORTS; o++) begin : g_lane
        port_t src_idx;

        assign src_idx         = port_t'(o) - slot;
        assign lanes[o].valid  = frame_vld[src_idx];
        assign lanes[o].src    = frame_cell[src_idx].src;
        assign lanes[o].dest   = frame_cell[src_idx].dest;
        assign lanes[o].data   = frame_cell[src_idx].data;
    end

    a_no_load_when_full : assert property (
        @(posedge clk) disable iff (!rst_n)
        (slot == LAST_SLOT && |alm_full_in) |=> (frame_vld == '0)
    ) else $error("frame_rotator: frame loaded while a queue is almost full");

endmodule

// ==== src/voq_buffer.sv ====
`timescale 1ns/1ps
`include "switch_defs.svh"

module voq_buffer #(
    parameter switch_pkg::port_t OUT_PORT = '0
) (
    input  logic                clk,
    input  logic                rst_n,
    cell_lane_if.receiver       lane,
    input  logic                rd_en,
    input  switch_pkg::port_t   rd_sel,
    output switch_pkg::data_t   rd_data,
    output logic [`SW_PORTS-1:0] empty,
    output logic                alm_full
);
    import switch_pkg::*;

    localparam int PTR_W  = $clog2(`SW_QUEUE_DEPTH);
    localparam int ADDR_W = $bits(port_t) + PTR_W;
    localparam int CNT_W  = PTR_W + 1;

    // Shared storage, the source index picks the region.
    data_t                mem [`SW_PORTS*`SW_QUEUE_DEPTH];

    logic [PTR_W-1:0]     wr_ptr [`SW_PORTS];
    logic [PTR_W-1:0]     rd_ptr [`SW_PORTS];
    logic [CNT_W-1:0]     count [`SW_PORTS];
    logic [`SW_PORTS-1:0] full;
    logic [`SW_PORTS-1:0] alm;
    logic [`SW_PORTS-1:0] push;
    logic [`SW_PORTS-1:0] pop;
    logic                 lane_hit;
    logic [ADDR_W-1:0]    wr_addr;
    logic [ADDR_W-1:0]    rd_addr;

    assign lane_hit = lane.valid && (lane.dest == OUT_PORT);

    // ******************************************************************
    // Per-queue flags and strobes.
    // ******************************************************************

    for (genvar q = 0; q < `SW_PORTS; q++) begin : g_queue
        assign empty[q] = (count[q] == '0);
        assign full[q]  = (count[q] == CNT_W'(`SW_QUEUE_DEPTH));
        assign alm[q]   = (count[q] >= CNT_W'(`SW_QUEUE_DEPTH - 1));
        assign push[q]  = lane_hit && (lane.src == port_t'(q)) && !full[q];
        assign pop[q]   = rd_en && (rd_sel == port_t'(q)) && !empty[q];
    end

    assign alm_full = |alm;

    // ******************************************************************
    // Storage and pointers.
    // ******************************************************************

    assign wr_addr = {lane.src, wr_ptr[lane.src]};
    assign rd_addr = {rd_sel, rd_ptr[rd_sel]};

    always_ff @(posedge clk) begin
        if (|push) begin
            mem[wr_addr] <= lane.data;
        end
    end

    // Head of the selected queue, shown before the pop.
    assign rd_data = mem[rd_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int q = 0; q < `SW_PORTS; q++) begin
                wr_ptr[q] <= '0;
                rd_ptr[q] <= '0;
                count[q]  <= '0;
            end
        end else begin
            for (int q = 0; q < `SW_PORTS; q++) begin
                if (push[q]) begin
                    wr_ptr[q] <= wr_ptr[q] + 1'b1;
                end
                if (pop[q]) begin
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                end
                if (push[q] && !pop[q]) begin
                    count[q] <= count[q] + 1'b1;
                end else if (!push[q] && pop[q]) begin
                    count[q] <= count[q] - 1'b1;
                end
            end
        end
    end

    // Back-pressure in the rotator must keep every queue from overflowing.
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        lane_hit |-> !full[lane.src]
    ) else $error("voq_buffer %0d: cell dropped on a full queue", OUT_PORT);

    a_no_underflow : assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_en |-> !empty[rd_sel]
    ) else $error("voq_buffer %0d: read of an empty queue", OUT_PORT);

endmodule

// ==== src/cell_switch.sv ====
`timescale 1ns/1ps
`include "switch_defs.svh"

module cell_switch (
    input  logic                                            clk,
    input  logic                                            rst_n,

    input  logic [`SW_PORTS-1:0]                            vld_in,
    input  logic [`SW_PORTS*$bits(switch_pkg::port_t)-1:0]  dest_in,
    input  logic [`SW_PORTS*`SW_DATA_W-1:0]                 data_in,
    output logic                                            ready,

    input  logic [`SW_PORTS-1:0]                            rd_en,
    input  logic [`SW_PORTS*$bits(switch_pkg::port_t)-1:0]  rd_sel,
    output logic [`SW_PORTS*`SW_PORTS-1:0]                  empty,
    output logic [`SW_PORTS*`SW_DATA_W-1:0]                 data_out,

    output logic                                            alm_ost_full
);
    import switch_pkg::*;

    localparam int PW = $bits(port_t);

    logic [`SW_PORTS-1:0] alm_full;

    cell_lane_if lane [`SW_PORTS] ();

    // ******************************************************************
    // Input side.
    // ******************************************************************

    frame_rotator u_rotator (
        .clk         (clk),
        .rst_n       (rst_n),
        .vld_in      (vld_in),
        .dest_in     (dest_in),
        .data_in     (data_in),
        .alm_full_in (alm_full),
        .ready       (ready),
        .lanes       (lane)
    );

    // ******************************************************************
    // Output buffers, one per lane.
    // ******************************************************************

    for (genvar o = 0; o < `SW_PORTS; o++) begin : g_out
        voq_buffer #(
            .OUT_PORT (port_t'(o))
        ) u_voq (
            .clk      (clk),
            .rst_n    (rst_n),
            .lane     (lane[o]),
            .rd_en    (rd_en[o]),
            .rd_sel   (rd_sel[o*PW +: PW]),
            .rd_data  (data_out[o*`SW_DATA_W +: `SW_DATA_W]),
            .empty    (empty[o*`SW_PORTS +: `SW_PORTS]),
            .alm_full (alm_full[o])
        );
    end

    assign alm_ost_full = |alm_full;

endmodule

// ==== sim/tb_cell_switch.sv ====
`timescale 1ns/1ps
`include "switch_defs.svh"

module tb_cell_switch;
    import switch_pkg::*;

    localparam int NP         = `SW_PORTS;
    localparam int PW         = $bits(port_t);
    localparam int DW         = `SW_DATA_W;
    localparam int DEPTH      = `SW_QUEUE_DEPTH;
    localparam int MAX_CYCLES = 20000;

    logic             clk;
    logic             rst_n;
    logic [NP-1:0]    vld_in;
    logic [NP*PW-1:0] dest_in;
    logic [NP*DW-1:0] data_in;
    logic             ready;
    logic [NP-1:0]    rd_en;
    logic [NP*PW-1:0] rd_sel;
    logic [NP*NP-1:0] empty;
    logic [NP*DW-1:0] data_out;
    logic             alm_ost_full;

    // Expected words per queue, indexed output*NP+source, kept as rings.
    data_t            sb_mem [NP*NP][16];
    int               sb_wr [NP*NP];
    int               sb_rd [NP*NP];
    logic [NP*NP-1:0] last_frame;

    logic [31:0]      lfsr = 32'h80a45ca9;
    int               cycle_cnt = 0;
    int               errors = 0;
    int               tests_ok = 0;
    int               tests_bad = 0;

    cell_switch dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .vld_in       (vld_in),
        .dest_in      (dest_in),
        .data_in      (data_in),
        .ready        (ready),
        .rd_en        (rd_en),
        .rd_sel       (rd_sel),
        .empty        (empty),
        .data_out     (data_out),
        .alm_ost_full (alm_ost_full)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Testbench failed");
            $finish;
        end
    end

    // **********************************************************************
    // Helpers.
    // **********************************************************************

    // Fibonacci LFSR with taps 32, 22, 2, 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int b = 0; b < n; b++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic int queued(input int k);
        return sb_wr[k] - sb_rd[k];
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp, got);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic end_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    // The frame is held on the inputs until a slot-3 cycle with ready high ends.
    task automatic send_frame(input logic [NP-1:0] vld, input logic [NP*PW-1:0] dest,
                              input logic [NP*DW-1:0] data);
        bit taken;
        int k;
        taken = 1'b0;
        @(posedge clk);
        vld_in  <= vld;
        dest_in <= dest;
        data_in <= data;
        while (!taken) begin
            @(negedge clk);
            taken = ready;
            @(posedge clk);
        end
        vld_in     <= '0;
        last_frame = '0;
        for (int i = 0; i < NP; i++) begin
            if (vld[i]) begin
                k = dest[i*PW +: PW] * NP + i;
                sb_mem[k][sb_wr[k] % 16] = data[i*DW +: DW];
                sb_wr[k]++;
                last_frame[k] = 1'b1;
            end
        end
    endtask

    task automatic read_cell(input int o, input int s);
        int               k;
        data_t            exp_word;
        logic [NP*PW-1:0] sel;
        k = o * NP + s;
        if (queued(k) == 0) begin
            $display("Error at %0t: read of queue %0d/%0d with no cell expected", $time, o, s);
            errors++;
        end else begin
            exp_word = sb_mem[k][sb_rd[k] % 16];
            sb_rd[k]++;
            sel = rd_sel;
            sel[o*PW +: PW] = PW'(s);
            @(posedge clk);
            rd_sel <= sel;
            rd_en  <= NP'(1) << o;
            @(negedge clk);
            if (empty[k] !== 1'b0) report_mismatch("empty bit", 64'h0, 64'(empty[k]));
            if (data_out[o*DW +: DW] !== exp_word) begin
                report_mismatch("data_out", 64'(exp_word), 64'(data_out[o*DW +: DW]));
            end
            @(posedge clk);
            rd_en <= '0;
        end
    endtask

    // **********************************************************************
    // Tests.
    // **********************************************************************

    task automatic check_reset_state();
        int   err_start;
        logic exp_rdy;
        err_start = errors;
        for (int n = 0; n < 12; n++) begin
            @(negedge clk);
            exp_rdy = (n % NP == NP - 1);
            if (ready !== exp_rdy) report_mismatch("ready", 64'(exp_rdy), 64'(ready));
            if (empty !== '1) report_mismatch("empty", {(NP*NP){1'b1}}, 64'(empty));
            if (alm_ost_full !== 1'b0) report_mismatch("alm_ost_full", 64'h0, 64'(alm_ost_full));
        end
        end_test("reset state", err_start);
    endtask

    task automatic route_single_cells();
        int               err_start;
        int               k;
        int               lat;
        logic [NP-1:0]    vld;
        logic [NP*PW-1:0] dest;
        logic [NP*DW-1:0] data;
        logic [NP*NP-1:0] exp_empty;
        err_start = errors;
        for (int i = 0; i < NP; i++) begin
            for (int d = 0; d < NP; d++) begin
                vld = '0;
                dest = '0;
                data = '0;
                vld[i] = 1'b1;
                dest[i*PW +: PW] = PW'(d);
                data[i*DW +: DW] = DW'(rand_bits(DW));
                k   = d * NP + i;
                lat = 1 + (d - i + NP) % NP;
                send_frame(vld, dest, data);
                // The n-th falling edge follows the n-th rising edge after capture.
                for (int n = 0; n <= NP; n++) begin
                    @(negedge clk);
                    exp_empty = '1;
                    if (n >= lat) exp_empty[k] = 1'b0;
                    if (empty !== exp_empty) report_mismatch("empty", 64'(exp_empty), 64'(empty));
                end
                read_cell(d, i);
            end
        end
        end_test("single-cell routing", err_start);
    endtask

    task automatic permute_full_frame();
        int               err_start;
        logic [NP*PW-1:0] dest;
        logic [NP*DW-1:0] data;
        logic [NP*NP-1:0] exp_empty;
        err_start = errors;
        exp_empty = '1;
        for (int i = 0; i < NP; i++) begin
            dest[i*PW +: PW] = PW'((3 * i + 1) % NP);
            data[i*DW +: DW] = DW'(rand_bits(DW));
            exp_empty[((3 * i + 1) % NP) * NP + i] = 1'b0;
        end
        send_frame('1, dest, data);
        repeat (NP) @(posedge clk);
        @(negedge clk);
        if (empty !== exp_empty) report_mismatch("empty", 64'(exp_empty), 64'(empty));
        for (int i = 0; i < NP; i++) read_cell((3 * i + 1) % NP, i);
        end_test("full-frame permutation", err_start);
    endtask

    task automatic merge_to_one_output();
        int               err_start;
        logic [NP*PW-1:0] dest;
        logic [NP*DW-1:0] data;
        logic [NP*NP-1:0] exp_empty;
        err_start = errors;
        for (int i = 0; i < NP; i++) dest[i*PW +: PW] = PW'(2);
        for (int f = 0; f < 5; f++) begin
            for (int i = 0; i < NP; i++) data[i*DW +: DW] = DW'(rand_bits(DW));
            send_frame('1, dest, data);
        end
        repeat (NP) @(posedge clk);
        @(negedge clk);
        exp_empty = '1;
        exp_empty[2*NP +: NP] = '0;
        if (empty !== exp_empty) report_mismatch("empty", 64'(exp_empty), 64'(empty));
        for (int s = 0; s < NP; s++) begin
            for (int f = 0; f < 5; f++) read_cell(2, s);
        end
        end_test("many-to-one ordering", err_start);
    endtask

    task automatic apply_back_pressure();
        int               err_start;
        bit               back;
        logic [NP*PW-1:0] dest;
        logic [NP*DW-1:0] data;
        logic [NP*NP-1:0] exp_empty;
        err_start = errors;
        dest = '0;
        dest[PW-1:0] = PW'(1);
        for (int n = 0; n < DEPTH - 1; n++) begin
            data = '0;
            data[DW-1:0] = DW'(rand_bits(DW));
            send_frame(NP'(1), dest, data);
        end
        repeat (3) @(posedge clk);
        // Cells offered while the switch is blocked must never reach a queue.
        vld_in  <= '1;
        dest_in <= '0;
        exp_empty = '1;
        exp_empty[NP] = 1'b0;
        for (int n = 0; n < 2 * NP; n++) begin
            @(negedge clk);
            if (alm_ost_full !== 1'b1) report_mismatch("alm_ost_full", 64'h1, 64'(alm_ost_full));
            if (ready !== 1'b0) report_mismatch("ready", 64'h0, 64'(ready));
            if (empty !== exp_empty) report_mismatch("empty", 64'(exp_empty), 64'(empty));
        end
        @(posedge clk);
        vld_in <= '0;
        read_cell(1, 0);
        back = 1'b0;
        for (int n = 0; n < NP && !back; n++) begin
            @(negedge clk);
            back = ready;
        end
        if (!back) begin
            $display("Error at %0t: ready did not return after a read freed the queue", $time);
            errors++;
        end
        while (queued(NP) > 0) read_cell(1, 0);
        end_test("back-pressure", err_start);
    endtask

    task automatic run_random_traffic();
        int               err_start;
        int               k;
        logic [NP-1:0]    vld;
        logic [NP*PW-1:0] dest;
        logic [NP*DW-1:0] data;
        err_start = errors;
        for (int f = 0; f < 200; f++) begin
            // Keep every queue below the almost-full level before offering a frame.
            for (int q = 0; q < NP * NP; q++) begin
                while (queued(q) >= DEPTH - 1) read_cell(q / NP, q % NP);
            end
            vld  = NP'(rand_bits(NP));
            dest = rand_bits(NP * PW);
            for (int i = 0; i < NP; i++) data[i*DW +: DW] = DW'(rand_bits(DW));
            send_frame(vld, dest, data);
            for (int r = 0; r < 2; r++) begin
                k = rand_bits(PW) * NP + rand_bits(PW);
                if (queued(k) > int'(last_frame[k])) read_cell(k / NP, k % NP);
            end
        end
        repeat (NP + 1) @(posedge clk);
        for (int q = 0; q < NP * NP; q++) begin
            while (queued(q) > 0) read_cell(q / NP, q % NP);
        end
        @(negedge clk);
        if (empty !== '1) report_mismatch("empty", {(NP*NP){1'b1}}, 64'(empty));
        if (alm_ost_full !== 1'b0) report_mismatch("alm_ost_full", 64'h0, 64'(alm_ost_full));
        end_test("random traffic", err_start);
    endtask

    initial begin
        rst_n      = 1'b0;
        vld_in     = '0;
        dest_in    = '0;
        data_in    = '0;
        rd_en      = '0;
        rd_sel     = '0;
        last_frame = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        check_reset_state();
        route_single_cells();
        permute_full_frame();
        merge_to_one_output();
        apply_back_pressure();
        run_random_traffic();
        $display("Tests: %0d ok, %0d with errors, %0d errors in total",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+src
src/switch_pkg.sv
src/cell_lane_if.sv
src/frame_rotator.sv
src/voq_buffer.sv
src/cell_switch.sv
sim/tb_cell_switch.sv

// ==== Bender.yml ====
package:
  name: cell_switch

export_include_dirs:
  - src

sources:
  - src/switch_pkg.sv
  - src/cell_lane_if.sv
  - src/frame_rotator.sv
  - src/voq_buffer.sv
  - src/cell_switch.sv
  - target: test
    files:
      - sim/tb_cell_switch.sv
